// File: hdl/of_settings.svh
`ifndef OF_SETTINGS_SVH
`define OF_SETTINGS_SVH

////////////////////
// frame geometry

// active pixels per line, 800 for the real sensor
`define OF_LINE_PIXELS   16
// window edge in rows and columns
`define OF_WIN_SIZE      5

////////////////////
// datapath widths

`define OF_GRAD_W        9      // signed gradient
`define OF_PROD_W        18     // gradient product
`define OF_SUM_W         22     // window sum of 25 products
`define OF_TERM_W        64     // cramer terms

// fixed point applied to the sums before the solver
`define OF_FRAC_BITS     8
`define OF_LAMBDA        4096   // 16.0 regularization

// de in to flow_valid out
`define OF_PIPE_LATENCY  9

`endif

// File: hdl/of_pkg.sv
`include "of_settings.svh"

package of_pkg;

	typedef logic [7:0] luma_t;

	// current and previous frame luma, same position
	typedef struct packed {
		luma_t cur;
		luma_t prev;
	} luma_pair_t;

	typedef logic signed [`OF_GRAD_W-1:0] grad_t;

	typedef struct packed {
		grad_t ix;
		grad_t iy;
		grad_t it;
	} grad_set_t;

	typedef logic signed [`OF_PROD_W-1:0] prod_t;
	typedef logic signed [`OF_SUM_W-1:0]  sum_t;

	////////////////////
	// structure tensor entries
	typedef struct packed {
		prod_t ixix;
		prod_t ixiy;
		prod_t iyiy;
		prod_t ixit;
		prod_t iyit;
	} prod_set_t;

	typedef struct packed {
		sum_t ixix;
		sum_t ixiy;
		sum_t iyiy;
		sum_t ixit;
		sum_t iyit;
	} sum_set_t;

	typedef logic signed [`OF_TERM_W-1:0] term_t;

	typedef enum logic [1:0] {IDLE, ACTIVE, BLANK} line_state_e;

endpackage

// File: hdl/of_stream_if.sv
`timescale 1ns/1ps

// pixel stream between stages, one pixel per clock with de high
interface of_stream_if import of_pkg::*;
#(
	parameter type payload_t = luma_pair_t
)
();

	logic     de;      // pixel valid
	logic     hsync;   // high over the active part of a line
	logic     vsync;   // high over a frame
	payload_t data;

	modport src
	(
		output de,
		output hsync,
		output vsync,
		output data
	);

	modport snk
	(
		input de,
		input hsync,
		input vsync,
		input data
	);

endinterface

// File: hdl/of_luma_convert.sv
`timescale 1ns/1ps

module of_luma_convert import of_pkg::*;
(
	input  logic          RGB565_PCLK,
	input  logic          sys_rst_n,
	input  logic          rgb565_hsync,
	input  logic          rgb565_vsync,
	input  logic          rgb565_de,
	input  logic [15:0]   rgb565_d,
	input  logic [15:0]   prev_d,
	of_stream_if.src      luma_out
);

	logic [15:0] sum_cur_q;
	logic [15:0] sum_prev_q;
	logic        de_q, hs_q, vs_q;

	// 77 r + 150 g + 29 b, fields widened by bit replication
	function automatic logic [15:0] weighted(logic [15:0] px);
		logic [7:0] r, g, b;
		r = {px[15:11], px[15:13]};
		g = {px[10:5], px[10:9]};
		b = {px[4:0], px[4:2]};
		return 16'd77 * r + 16'd150 * g + 16'd29 * b;   // peaks at 65280
	endfunction

	always_ff @(posedge RGB565_PCLK)
	begin
		sum_cur_q  <= weighted(rgb565_d);
		sum_prev_q <= weighted(prev_d);
	end

	always_ff @(posedge RGB565_PCLK)
	begin
		if (!sys_rst_n)
		begin
			de_q <= 1'b0;
			hs_q <= 1'b0;
			vs_q <= 1'b0;
		end
		else
		begin
			de_q <= rgb565_de;
			hs_q <= rgb565_hsync;
			vs_q <= rgb565_vsync;
		end
	end

	assign luma_out.de    = de_q;
	assign luma_out.hsync = hs_q;
	assign luma_out.vsync = vs_q;
	assign luma_out.data  = '{cur: luma_t'(sum_cur_q[15:8]), prev: luma_t'(sum_prev_q[15:8])};

endmodule

// File: hdl/of_gradient_unit.sv
`timescale 1ns/1ps
`include "of_settings.svh"

module of_gradient_unit import of_pkg::*;
(
	input  logic     RGB565_PCLK,
	input  logic     sys_rst_n,
	of_stream_if.snk luma_in,
	of_stream_if.src grad_out
);

	luma_t     left_q;                        // previous pixel on this line
	luma_t     line_buf [`OF_LINE_PIXELS];    // one line of luma
	luma_t     above;
	grad_set_t grad_q;
	logic      de_q, hs_q, vs_q;

	function automatic grad_t diff(luma_t p, luma_t q);
		return $signed({1'b0, p}) - $signed({1'b0, q});
	endfunction

	assign above = line_buf[`OF_LINE_PIXELS-1];

	always_ff @(posedge RGB565_PCLK)
	begin
		if (!luma_in.hsync)
			left_q <= '0;                     // nothing left of the first pixel
		else if (luma_in.de)
			left_q <= luma_in.data.cur;
	end

	// zero above the first line of a frame
	always_ff @(posedge RGB565_PCLK)
	begin
		if (!luma_in.vsync)
		begin
			for (int i = 0; i < `OF_LINE_PIXELS; i++)
				line_buf[i] <= '0;
		end
		else if (luma_in.de)
		begin
			line_buf[0] <= luma_in.data.cur;
			for (int i = 1; i < `OF_LINE_PIXELS; i++)
				line_buf[i] <= line_buf[i-1];
		end
	end

	always_ff @(posedge RGB565_PCLK)
	begin
		grad_q.ix <= diff(luma_in.data.cur, left_q);
		grad_q.iy <= diff(luma_in.data.cur, above);
		grad_q.it <= diff(luma_in.data.cur, luma_in.data.prev);
	end

	always_ff @(posedge RGB565_PCLK)
	begin
		if (!sys_rst_n)
		begin
			de_q <= 1'b0;
			hs_q <= 1'b0;
			vs_q <= 1'b0;
		end
		else
		begin
			de_q <= luma_in.de;
			hs_q <= luma_in.hsync;
			vs_q <= luma_in.vsync;
		end
	end

	assign grad_out.de    = de_q;
	assign grad_out.hsync = hs_q;
	assign grad_out.vsync = vs_q;
	assign grad_out.data  = grad_q;

	// left register and column alignment rely on de only inside a line
	a_de_in_line: assert property (@(posedge RGB565_PCLK) disable iff (!sys_rst_n)
		luma_in.de |-> luma_in.hsync)
		else $error("de high outside hsync");

endmodule

// File: hdl/of_window_accumulator.sv
`timescale 1ns/1ps
`include "of_settings.svh"

module of_window_accumulator import of_pkg::*;
(
	input  logic     RGB565_PCLK,
	input  logic     sys_rst_n,
	of_stream_if.snk grad_in,
	of_stream_if.src sum_out
);

	localparam int WIN   = `OF_WIN_SIZE;
	localparam int LINE  = `OF_LINE_PIXELS;
	localparam int DEPTH = (WIN - 1) * LINE;

	grad_set_t   line_store [DEPTH];   // win-1 lines above
	grad_set_t   column     [WIN];
	prod_set_t   prod_q     [WIN];
	sum_set_t    col_acc;
	sum_set_t    col_sum_q;
	sum_set_t    col_hist   [WIN];     // column sums of the last win pixels
	sum_set_t    run_q;
	logic [2:0]  de_d, hs_d, vs_d;
	line_state_e line_state;

	function automatic prod_set_t products(grad_set_t g);
		prod_set_t p;
		p.ixix = g.ix * g.ix;
		p.ixiy = g.ix * g.iy;
		p.iyiy = g.iy * g.iy;
		p.ixit = g.ix * g.it;
		p.iyit = g.iy * g.it;
		return p;
	endfunction

	function automatic sum_set_t add_prod(sum_set_t s, prod_set_t p);
		sum_set_t r;
		r.ixix = s.ixix + p.ixix;
		r.ixiy = s.ixiy + p.ixiy;
		r.iyiy = s.iyiy + p.iyiy;
		r.ixit = s.ixit + p.ixit;
		r.iyit = s.iyit + p.iyit;
		return r;
	endfunction

	// new column in, oldest column out
	function automatic sum_set_t slide(sum_set_t run, sum_set_t add, sum_set_t sub);
		sum_set_t r;
		r.ixix = run.ixix + add.ixix - sub.ixix;
		r.ixiy = run.ixiy + add.ixiy - sub.ixiy;
		r.iyiy = run.iyiy + add.iyiy - sub.iyiy;
		r.ixit = run.ixit + add.ixit - sub.ixit;
		r.iyit = run.iyit + add.iyit - sub.iyit;
		return r;
	endfunction

	always_ff @(posedge RGB565_PCLK)
	begin
		if (!grad_in.vsync)
		begin
			for (int i = 0; i < DEPTH; i++)
				line_store[i] <= '0;
		end
		else if (grad_in.de)
		begin
			line_store[0] <= grad_in.data;
			for (int i = 1; i < DEPTH; i++)
				line_store[i] <= line_store[i-1];
		end
	end

	always_comb
	begin
		column[0] = grad_in.data;
		for (int k = 1; k < WIN; k++)
			column[k] = line_store[k*LINE-1];   // same column, k lines up
	end

	always_comb
	begin
		col_acc = '0;
		for (int k = 0; k < WIN; k++)
			col_acc = add_prod(col_acc, prod_q[k]);
	end

	////////////////////
	// products, column sum, running sum

	always_ff @(posedge RGB565_PCLK)
	begin
		for (int k = 0; k < WIN; k++)
			prod_q[k] <= products(column[k]);
		col_sum_q <= col_acc;
	end

	always_ff @(posedge RGB565_PCLK)
	begin
		if (line_state != ACTIVE)
		begin
			run_q <= '0;
			for (int k = 0; k < WIN; k++)
				col_hist[k] <= '0;
		end
		else if (de_d[1])
		begin
			run_q       <= slide(run_q, col_sum_q, col_hist[WIN-1]);
			col_hist[0] <= col_sum_q;
			for (int k = 1; k < WIN; k++)
				col_hist[k] <= col_hist[k-1];
		end
	end

	// follows hsync one stage late, so it lines up with col_sum_q
	always_ff @(posedge RGB565_PCLK)
	begin
		if (!sys_rst_n)
			line_state <= IDLE;
		else if (!vs_d[0])
			line_state <= IDLE;
		else
		begin
			case (line_state)
				IDLE, BLANK: if (hs_d[0]) line_state <= ACTIVE;
				ACTIVE:      if (!hs_d[0]) line_state <= BLANK;
				default:     line_state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge RGB565_PCLK)
	begin
		if (!sys_rst_n)
		begin
			de_d <= '0;
			hs_d <= '0;
			vs_d <= '0;
		end
		else
		begin
			de_d <= {de_d[1:0], grad_in.de};
			hs_d <= {hs_d[1:0], grad_in.hsync};
			vs_d <= {vs_d[1:0], grad_in.vsync};
		end
	end

	assign sum_out.de    = de_d[2];
	assign sum_out.hsync = hs_d[2];
	assign sum_out.vsync = vs_d[2];
	assign sum_out.data  = run_q;

	// squares only, so a negative sum means the slide lost a column
	a_squares_pos: assert property (@(posedge RGB565_PCLK) disable iff (!sys_rst_n)
		sum_out.de |-> (run_q.ixix >= 0 && run_q.iyiy >= 0))
		else $error("negative square sum in window");

endmodule

// File: hdl/of_flow_solver.sv
`timescale 1ns/1ps
`include "of_settings.svh"

module of_flow_solver import of_pkg::*;
(
	input  logic       RGB565_PCLK,
	input  logic       sys_rst_n,
	of_stream_if.snk   sum_in,
	output logic       flow_valid,
	output term_t      flow_denom,
	output term_t      flow_numer_u,
	output term_t      flow_numer_v,
	output logic [1:0] flow_frame
);

	localparam int SCALED_W = `OF_SUM_W + `OF_FRAC_BITS + 2;

	typedef logic signed [SCALED_W-1:0] scaled_t;

	scaled_t    a_q, d_q, b_q, e_q, f_q;   // a and d carry lambda
	term_t      p_ad, p_bb, p_be, p_bf, p_de, p_af;
	term_t      denom_q, numer_u_q, numer_v_q;
	logic [3:0] de_d;
	logic       vs_q;
	logic [1:0] frame_q;

	function automatic scaled_t scale(sum_t s);
		scaled_t w;
		w = s;
		return w <<< `OF_FRAC_BITS;
	endfunction

	always_ff @(posedge RGB565_PCLK)
	begin
		a_q <= scale(sum_in.data.ixix) + scaled_t'(`OF_LAMBDA);
		d_q <= scale(sum_in.data.iyiy) + scaled_t'(`OF_LAMBDA);
		b_q <= scale(sum_in.data.ixiy);   // b and c are the same sum
		e_q <= scale(sum_in.data.ixit);
		f_q <= scale(sum_in.data.iyit);
		p_ad <= a_q * d_q;
		p_bb <= b_q * b_q;
		p_be <= b_q * e_q;
		p_bf <= b_q * f_q;
		p_de <= d_q * e_q;
		p_af <= a_q * f_q;
		denom_q   <= p_ad - p_bb;
		numer_u_q <= p_de - p_bf;
		numer_v_q <= p_af - p_be;
		flow_denom   <= denom_q;
		flow_numer_u <= numer_u_q;
		flow_numer_v <= numer_v_q;
	end

	always_ff @(posedge RGB565_PCLK)
	begin
		if (!sys_rst_n)
		begin
			de_d    <= '0;
			vs_q    <= 1'b0;
			frame_q <= '0;
		end
		else
		begin
			de_d <= {de_d[2:0], sum_in.de};
			vs_q <= sum_in.vsync;
			if (vs_q && !sum_in.vsync)
				frame_q <= frame_q + 2'd1;   // end of frame, wraps at 4
		end
	end

	assign flow_valid = de_d[3];
	assign flow_frame = frame_q;

	// regularized tensor is positive definite
	a_denom_pos: assert property (@(posedge RGB565_PCLK) disable iff (!sys_rst_n)
		flow_valid |-> flow_denom > 0)
		else $error("flow_denom not positive");

endmodule

// File: hdl/of_top.sv
`timescale 1ns/1ps

module of_top import of_pkg::*;
(
	input  logic        RGB565_PCLK,
	input  logic        sys_rst_n,
	input  logic        rgb565_hsync,
	input  logic        rgb565_vsync,
	input  logic        rgb565_de,
	input  logic [15:0] rgb565_d,       // current frame
	input  logic [15:0] prev_d,         // previous frame, same pixel
	output logic        flow_valid,
	output term_t       flow_denom,
	output term_t       flow_numer_u,
	output term_t       flow_numer_v,
	output logic [1:0]  flow_frame
);

	of_stream_if #(.payload_t(luma_pair_t)) luma_if ();
	of_stream_if #(.payload_t(grad_set_t))  grad_if ();
	of_stream_if #(.payload_t(sum_set_t))   sum_if ();

	////////////////////
	// luma, gradients, window, cramer

	of_luma_convert i_luma_convert
	(
		.RGB565_PCLK  (RGB565_PCLK),
		.sys_rst_n    (sys_rst_n),
		.rgb565_hsync (rgb565_hsync),
		.rgb565_vsync (rgb565_vsync),
		.rgb565_de    (rgb565_de),
		.rgb565_d     (rgb565_d),
		.prev_d       (prev_d),
		.luma_out     (luma_if.src)
	);

	of_gradient_unit i_gradient_unit
	(
		.RGB565_PCLK (RGB565_PCLK),
		.sys_rst_n   (sys_rst_n),
		.luma_in     (luma_if.snk),
		.grad_out    (grad_if.src)
	);

	of_window_accumulator i_window_accumulator
	(
		.RGB565_PCLK (RGB565_PCLK),
		.sys_rst_n   (sys_rst_n),
		.grad_in     (grad_if.snk),
		.sum_out     (sum_if.src)
	);

	of_flow_solver i_flow_solver
	(
		.RGB565_PCLK  (RGB565_PCLK),
		.sys_rst_n    (sys_rst_n),
		.sum_in       (sum_if.snk),
		.flow_valid   (flow_valid),
		.flow_denom   (flow_denom),
		.flow_numer_u (flow_numer_u),
		.flow_numer_v (flow_numer_v),
		.flow_frame   (flow_frame)
	);

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

// 100 ns pixel clock, reset low over the first 5 rising edges
module tb_clock_gen
(
	output logic RGB565_PCLK,
	output logic sys_rst_n
);

	initial
	begin
		RGB565_PCLK = 1'b0;
		forever #50 RGB565_PCLK = ~RGB565_PCLK;
	end

	initial
	begin
		sys_rst_n = 1'b0;
		repeat (5) @(posedge RGB565_PCLK);
		#10 sys_rst_n = 1'b1;   // released like any other input
	end

endmodule

// File: test/tb_of_top.sv
`timescale 1ns/1ps
`include "of_settings.svh"

module tb_of_top import of_pkg::*;
();

	localparam int     LINE    = `OF_LINE_PIXELS;
	localparam int     ROWS    = 6;
	localparam int     WIN     = `OF_WIN_SIZE;
	localparam int     NPIX    = LINE * ROWS;
	localparam int     LAT     = `OF_PIPE_LATENCY;
	localparam int     TIMEOUT = 200;                  // cycles per wait loop
	localparam longint LAMBDA  = `OF_LAMBDA;
	localparam longint SCALE   = longint'(1) << `OF_FRAC_BITS;

	logic        RGB565_PCLK;
	logic        sys_rst_n;
	logic        rgb565_hsync, rgb565_vsync, rgb565_de;
	logic [15:0] rgb565_d, prev_d;
	logic        flow_valid;
	term_t       flow_denom, flow_numer_u, flow_numer_v;
	logic [1:0]  flow_frame;

	logic [15:0] cur_px  [ROWS][LINE];
	logic [15:0] prev_px [ROWS][LINE];
	int          gx [ROWS][LINE];
	int          gy [ROWS][LINE];
	int          gt [ROWS][LINE];
	longint      exp_den [NPIX];
	longint      exp_u   [NPIX];
	longint      exp_v   [NPIX];
	longint      got_den [NPIX];
	longint      got_u   [NPIX];
	longint      got_v   [NPIX];
	int          de_cycle    [NPIX];   // cycle each input pixel was driven
	int          valid_cycle [NPIX];
	int          pix_cnt, got_cnt, cycle;
	int          errors, checks, err_at_start, tests_run, tests_failed;
	bit          timed_out;
	string       test_name;
	logic [31:0] rng_state;

	tb_clock_gen i_clock_gen
	(
		.RGB565_PCLK (RGB565_PCLK),
		.sys_rst_n   (sys_rst_n)
	);

	of_top i_dut
	(
		.RGB565_PCLK  (RGB565_PCLK),
		.sys_rst_n    (sys_rst_n),
		.rgb565_hsync (rgb565_hsync),
		.rgb565_vsync (rgb565_vsync),
		.rgb565_de    (rgb565_de),
		.rgb565_d     (rgb565_d),
		.prev_d       (prev_d),
		.flow_valid   (flow_valid),
		.flow_denom   (flow_denom),
		.flow_numer_u (flow_numer_u),
		.flow_numer_v (flow_numer_v),
		.flow_frame   (flow_frame)
	);

	function automatic logic [31:0] xorshift(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// fields widened by bit replication, then weighted
	function automatic int luma_of(logic [15:0] px);
		int r, g, b;
		r = {px[15:11], px[15:13]};
		g = {px[10:5], px[10:9]};
		b = {px[4:0], px[4:2]};
		return (77 * r + 150 * g + 29 * b) >> 8;
	endfunction

	task automatic check_value(string what, longint exp, longint act);
		checks++;
		assert (act == exp)
		else
		begin
			$display("FAIL %s %s: expected %0d, actual %0d", test_name, what, exp, act);
			errors++;
		end
	endtask

	////////////////////
	// reference model

	task automatic build_model();
		int     lc;
		longint sxx, sxy, syy, sxt, syt;
		longint a, b, d, e, f;
		for (int r = 0; r < ROWS; r++)
			for (int c = 0; c < LINE; c++)
			begin
				lc = luma_of(cur_px[r][c]);
				gx[r][c] = lc - ((c > 0) ? luma_of(cur_px[r][c-1]) : 0);
				gy[r][c] = lc - ((r > 0) ? luma_of(cur_px[r-1][c]) : 0);
				gt[r][c] = lc - luma_of(prev_px[r][c]);
			end
		for (int r = 0; r < ROWS; r++)
			for (int c = 0; c < LINE; c++)
			begin
				sxx = 0;
				sxy = 0;
				syy = 0;
				sxt = 0;
				syt = 0;
				for (int rr = r - WIN + 1; rr <= r; rr++)
					for (int cc = c - WIN + 1; cc <= c; cc++)
						if (rr >= 0 && cc >= 0)   // outside the frame counts as zero
						begin
							sxx += gx[rr][cc] * gx[rr][cc];
							sxy += gx[rr][cc] * gy[rr][cc];
							syy += gy[rr][cc] * gy[rr][cc];
							sxt += gx[rr][cc] * gt[rr][cc];
							syt += gy[rr][cc] * gt[rr][cc];
						end
				a = sxx * SCALE + LAMBDA;
				d = syy * SCALE + LAMBDA;
				b = sxy * SCALE;
				e = sxt * SCALE;
				f = syt * SCALE;
				exp_den[r*LINE+c] = a * d - b * b;
				exp_u[r*LINE+c]   = d * e - b * f;
				exp_v[r*LINE+c]   = a * f - b * e;
			end
	endtask

	////////////////////
	// stream driver and output collection

	task automatic collect();
		if (flow_valid === 1'b1)
		begin
			if (got_cnt >= pix_cnt || got_cnt >= NPIX)
			begin
				$display("%s: flow_valid pulse with no input pixel behind it", test_name);
				errors++;
			end
			else
			begin
				valid_cycle[got_cnt] = cycle;
				got_den[got_cnt]     = flow_denom;
				got_u[got_cnt]       = flow_numer_u;
				got_v[got_cnt]       = flow_numer_v;
				check_value("flow_denom", exp_den[got_cnt], flow_denom);
				check_value("flow_numer_u", exp_u[got_cnt], flow_numer_u);
				check_value("flow_numer_v", exp_v[got_cnt], flow_numer_v);
			end
			got_cnt++;
		end
	endtask

	task automatic step(logic hs, logic vs, logic en, logic [15:0] cd, logic [15:0] pd);
		@(posedge RGB565_PCLK);
		cycle++;
		#10;
		rgb565_hsync = hs;
		rgb565_vsync = vs;
		rgb565_de    = en;
		rgb565_d     = cd;
		prev_d       = pd;
		if (en && pix_cnt < NPIX)
		begin
			de_cycle[pix_cnt] = cycle;
			pix_cnt++;
		end
		@(negedge RGB565_PCLK);   // outputs settled
		collect();
	endtask

	task automatic stream_frame();
		int         waited;
		logic [1:0] frame_before;
		build_model();
		frame_before = flow_frame;
		pix_cnt      = 0;
		got_cnt      = 0;
		repeat (2) step(1'b0, 1'b0, 1'b0, '0, '0);   // vsync low clears line stores
		repeat (2) step(1'b0, 1'b1, 1'b0, '0, '0);
		for (int r = 0; r < ROWS; r++)
		begin
			for (int c = 0; c < LINE; c++)
				step(1'b1, 1'b1, 1'b1, cur_px[r][c], prev_px[r][c]);
			repeat (4) step(1'b0, 1'b1, 1'b0, '0, '0);   // line blanking
		end
		waited = 0;
		while (got_cnt < NPIX && waited < TIMEOUT)
		begin
			step(1'b0, 1'b0, 1'b0, '0, '0);
			waited++;
		end
		if (got_cnt < NPIX)
		begin
			$display("%s: timed out with %0d of %0d results", test_name, got_cnt, NPIX);
			errors++;
			timed_out = 1'b1;
		end
		waited = 0;
		while (flow_frame == frame_before && waited < TIMEOUT)
		begin
			step(1'b0, 1'b0, 1'b0, '0, '0);
			waited++;
		end
		if (flow_frame == frame_before)
		begin
			$display("%s: frame index did not move after the frame ended", test_name);
			errors++;
		end
	endtask

	task automatic fill_constant(logic [15:0] cur_val, logic [15:0] prev_val);
		for (int r = 0; r < ROWS; r++)
			for (int c = 0; c < LINE; c++)
			begin
				cur_px[r][c]  = cur_val;
				prev_px[r][c] = prev_val;
			end
	endtask

	task automatic fill_random();
		for (int r = 0; r < ROWS; r++)
			for (int c = 0; c < LINE; c++)
			begin
				rng_state     = xorshift(rng_state);
				cur_px[r][c]  = rng_state[15:0];
				rng_state     = xorshift(rng_state);
				prev_px[r][c] = rng_state[15:0];
			end
	endtask

	task automatic begin_test(string name);
		test_name    = name;
		err_at_start = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors == err_at_start)
			$display("test %s: ok", test_name);
		else
		begin
			$display("test %s: %0d errors", test_name, errors - err_at_start);
			tests_failed++;
		end
	endtask

	////////////////////
	// directed tests

	task automatic test_reset();
		int waited;
		begin_test("reset");
		waited = 0;
		while (sys_rst_n !== 1'b1 && waited < TIMEOUT)
		begin
			step(1'b0, 1'b0, 1'b0, '0, '0);
			waited++;
		end
		if (sys_rst_n !== 1'b1)
		begin
			$display("%s: reset never released", test_name);
			errors++;
			timed_out = 1'b1;
		end
		checks++;
		assert (flow_valid === 1'b0 && flow_frame === 2'b00)
		else
		begin
			$display("FAIL %s: expected valid 0 frame 0, actual valid %b frame %b",
				test_name, flow_valid, flow_frame);
			errors++;
		end
		end_test();
	endtask

	task automatic test_constant();
		int idx;
		begin_test("constant");
		fill_constant(16'h7bef, 16'h7bef);
		stream_frame();
		// windows clear of the first row and column see no gradient at all
		for (int r = WIN; r < ROWS; r++)
			for (int c = WIN; c < LINE; c++)
			begin
				idx = r * LINE + c;
				check_value("interior denom", LAMBDA * LAMBDA, got_den[idx]);
				check_value("interior numer_u", 0, got_u[idx]);
				check_value("interior numer_v", 0, got_v[idx]);
			end
		end_test();
	endtask

	task automatic test_step();
		begin_test("brightness_step");
		fill_constant(16'h8c51, 16'h4208);   // it constant over the frame
		stream_frame();
		end_test();
	endtask

	task automatic test_random();
		begin_test("random");
		fill_random();
		stream_frame();
		end_test();
	endtask

	task automatic test_latency();
		begin_test("latency");
		fill_random();
		stream_frame();
		check_value("pulse count", pix_cnt, got_cnt);
		for (int i = 0; i < NPIX && i < got_cnt; i++)
			check_value("de to valid", LAT, valid_cycle[i] - de_cycle[i]);
		end_test();
	endtask

	task automatic test_frame_index();
		logic [1:0] start;
		begin_test("frame_index");
		start = flow_frame;
		for (int k = 1; k <= 4 && !timed_out; k++)
		begin
			fill_random();
			stream_frame();
			check_value("flow_frame", (start + k) % 4, flow_frame);   // wraps after 4
		end
		end_test();
	endtask

	initial
	begin
		rgb565_hsync = 1'b0;
		rgb565_vsync = 1'b0;
		rgb565_de    = 1'b0;
		rgb565_d     = '0;
		prev_d       = '0;
		rng_state    = 32'hffbc;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		cycle        = 0;
		pix_cnt      = 0;
		got_cnt      = 0;
		timed_out    = 1'b0;
		test_reset();
		if (!timed_out)
			test_constant();
		if (!timed_out)
			test_step();
		if (!timed_out)
			test_random();
		if (!timed_out)
			test_latency();
		if (!timed_out)
			test_frame_index();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && !timed_out)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+hdl
hdl/of_pkg.sv
hdl/of_stream_if.sv
hdl/of_luma_convert.sv
hdl/of_gradient_unit.sv
hdl/of_window_accumulator.sv
hdl/of_flow_solver.sv
hdl/of_top.sv
test/tb_clock_gen.sv
test/tb_of_top.sv
